// ==== qdr_host_bridge_defs.svh ====
`ifndef QDR_HOST_BRIDGE_DEFS_SVH
`define QDR_HOST_BRIDGE_DEFS_SVH

// cycles from the read grant to the first read beat on the sram data bus
// must be at least 2 for the valid shifter in the burst adapter
`define QDR_READ_LATENCY 9

// burst address width
// one burst address covers two 36-bit beats or eight host bytes
`define QDR_ADDR_W 29

`endif

// ==== qdr_host_bridge_pkg.sv ====
`default_nettype none

`include "qdr_host_bridge_defs.svh"

package qdr_host_bridge_pkg;

  // host register bus
  typedef logic [31:0] host_addr_t;
  typedef logic [31:0] host_data_t;
  typedef logic [3:0]  host_be_t;

  // sram side, one beat is four 9-bit lanes
  typedef logic [`QDR_ADDR_W-1:0] qdr_addr_t;
  typedef logic [35:0]            qdr_word_t;
  typedef logic [3:0]             qdr_be_t;

  typedef enum logic [1:0] {
    PORT_IDLE,
    PORT_REQ,
    PORT_DROP
  } port_state_e;

  typedef enum logic [1:0] {
    ADP_IDLE,
    ADP_WAIT,
    ADP_COLLECT,
    ADP_FINAL
  } adapter_state_e;

endpackage

`default_nettype wire

// ==== host_port.sv ====
`default_nettype none

module host_port
  import qdr_host_bridge_pkg::*;
(
  input  logic       qdr_clk,
  input  logic       qdr_rst,
  input  logic       host_en,
  input  logic       host_rnw,
  input  host_addr_t host_addr,
  input  host_data_t host_datai,
  input  host_be_t   host_be,
  input  logic       xfer_ack,
  input  host_data_t rd_data,
  output logic       host_ack,
  output host_data_t host_datao,
  output logic       xfer_req,
  output host_addr_t xfer_addr,
  output logic       xfer_rnw,
  output host_data_t xfer_data,
  output host_be_t   xfer_be
);

  port_state_e state;

  // request is a pure state decode so it comes straight off a flop
  assign xfer_req = (state == PORT_REQ);

  always_ff @(posedge qdr_clk) begin
    if (qdr_rst) begin
      state    <= PORT_IDLE;
      host_ack <= 1'b0;
    end else begin
      host_ack <= 1'b0;
      case (state)
        PORT_IDLE: begin
          if (host_en) begin
            state <= PORT_REQ;
          end
        end
        PORT_REQ: begin
          // adapter finished the burst, release the request
          if (xfer_ack) begin
            state <= PORT_DROP;
          end
        end
        PORT_DROP: begin
          // wait for the acknowledge to fall before closing the access
          if (!xfer_ack) begin
            state    <= PORT_IDLE;
            host_ack <= 1'b1;
          end
        end
        default: state <= PORT_IDLE;
      endcase
    end
  end

  // command held stable for the whole handshake
  always_ff @(posedge qdr_clk) begin
    if (state == PORT_IDLE && host_en) begin
      xfer_addr <= host_addr;
      xfer_rnw  <= host_rnw;
      xfer_data <= host_datai;
      xfer_be   <= host_be;
    end
  end

  // read data stays until the next read completes
  always_ff @(posedge qdr_clk) begin
    if (state == PORT_REQ && xfer_ack && xfer_rnw) begin
      host_datao <= rd_data;
    end
  end

  a_host_en_idle: assert property (@(posedge qdr_clk) disable iff (qdr_rst)
    host_en |-> state == PORT_IDLE);

endmodule

`default_nettype wire

// ==== qdr_burst_adapter.sv ====
`default_nettype none

`include "qdr_host_bridge_defs.svh"

module qdr_burst_adapter
  import qdr_host_bridge_pkg::*;
(
  input  logic       qdr_clk,
  input  logic       qdr_rst,
  input  logic       xfer_req,
  input  host_addr_t xfer_addr,
  input  logic       xfer_rnw,
  input  host_data_t xfer_data,
  input  host_be_t   xfer_be,
  input  logic       qdr_ack,
  input  qdr_word_t  qdr_q,
  output logic       xfer_ack,
  output host_data_t rd_data,
  output logic       qdr_req,
  output logic       qdr_r,
  output logic       qdr_w,
  output qdr_addr_t  qdr_addr,
  output qdr_word_t  qdr_d,
  output qdr_be_t    qdr_be
);

  adapter_state_e state;

  host_addr_t addr_q;
  host_data_t data_q;
  host_be_t   be_q;
  logic       rnw_q;

  // high during the second beat of the burst
  logic beat_one;
  // selects the beat that holds the host word
  logic beat_sel;
  logic rd_launch;
  logic [`QDR_READ_LATENCY-1:0] rd_vld;
  host_data_t q_bytes;
  logic take_beat;

  assign beat_sel  = addr_q[2];
  assign rd_launch = (state == ADP_WAIT) && qdr_ack && rnw_q;

  // drop the ninth bit of every lane
  assign q_bytes = {qdr_q[34:27], qdr_q[25:18], qdr_q[16:9], qdr_q[7:0]};

  assign take_beat = (state == ADP_FINAL) ||
                     (state == ADP_COLLECT && rnw_q && rd_vld[`QDR_READ_LATENCY-1] && !beat_sel);

  assign qdr_req  = (state == ADP_WAIT);
  assign qdr_r    = qdr_req & rnw_q;
  assign qdr_w    = qdr_req & ~rnw_q;
  assign qdr_addr = addr_q[`QDR_ADDR_W+2:3];
  assign qdr_d    = {1'b0, data_q[31:24], 1'b0, data_q[23:16],
                     1'b0, data_q[15:8], 1'b0, data_q[7:0]};
  assign qdr_be   = (beat_one == beat_sel) ? be_q : '0;

  // a request still high while xfer_ack is up is the one already served
  always_ff @(posedge qdr_clk) begin
    if (state == ADP_IDLE && xfer_req && !xfer_ack) begin
      addr_q <= xfer_addr;
      data_q <= xfer_data;
      be_q   <= xfer_be;
      rnw_q  <= xfer_rnw;
    end
  end

  always_ff @(posedge qdr_clk) begin
    if (qdr_rst) begin
      state    <= ADP_IDLE;
      xfer_ack <= 1'b0;
      beat_one <= 1'b0;
      rd_vld   <= '0;
    end else begin
      beat_one <= (state == ADP_WAIT) && qdr_ack;
      rd_vld   <= {rd_vld[`QDR_READ_LATENCY-2:0], rd_launch};

      // fourth phase of the handshake
      if (xfer_ack && !xfer_req) begin
        xfer_ack <= 1'b0;
      end

      case (state)
        ADP_IDLE: begin
          if (xfer_req && !xfer_ack) begin
            state <= ADP_WAIT;
          end
        end
        ADP_WAIT: begin
          if (qdr_ack) begin
            state <= ADP_COLLECT;
          end
        end
        ADP_COLLECT: begin
          if (!rnw_q) begin
            // write is done once beat 1 has gone out
            state    <= ADP_IDLE;
            xfer_ack <= 1'b1;
          end else if (rd_vld[`QDR_READ_LATENCY-1]) begin
            if (!beat_sel) begin
              state    <= ADP_IDLE;
              xfer_ack <= 1'b1;
            end else begin
              state <= ADP_FINAL;
            end
          end
        end
        ADP_FINAL: begin
          state    <= ADP_IDLE;
          xfer_ack <= 1'b1;
        end
        default: state <= ADP_IDLE;
      endcase
    end
  end

  always_ff @(posedge qdr_clk) begin
    if (take_beat) begin
      rd_data <= q_bytes;
    end
  end

  // under back-pressure the burst must not move
  a_req_held: assert property (@(posedge qdr_clk) disable iff (qdr_rst)
    qdr_req && !qdr_ack |=> qdr_req && $stable(qdr_addr) && $stable(qdr_d));

endmodule

`default_nettype wire

// ==== qdr_cmd_issue.sv ====
`default_nettype none

module qdr_cmd_issue
  import qdr_host_bridge_pkg::*;
(
  input  logic      qdr_clk,
  input  logic      qdr_rst,
  input  logic      qdr_req,
  input  logic      qdr_r,
  input  logic      qdr_w,
  input  qdr_addr_t qdr_addr,
  input  qdr_word_t qdr_d,
  input  qdr_be_t   qdr_be,
  input  qdr_word_t sram_q,
  output logic      qdr_ack,
  output qdr_word_t qdr_q,
  output qdr_addr_t sram_addr,
  output logic      sram_r_n,
  output logic      sram_w_n,
  output qdr_word_t sram_d,
  output qdr_be_t   sram_bw_n
);

  // second beat of the burst in flight
  logic in_beat1;
  // same, but only for a write burst
  logic wr_beat1;
  logic wr_beat;

  // the port is busy for two cycles per burst
  assign qdr_ack = qdr_req && !in_beat1;
  assign wr_beat = (qdr_ack && qdr_w) || wr_beat1;

  // read data comes back unregistered
  assign qdr_q = sram_q;

  always_ff @(posedge qdr_clk) begin
    if (qdr_rst) begin
      in_beat1  <= 1'b0;
      wr_beat1  <= 1'b0;
      sram_r_n  <= 1'b1;
      sram_w_n  <= 1'b1;
      sram_bw_n <= '1;
    end else begin
      in_beat1  <= qdr_ack;
      wr_beat1  <= qdr_ack && qdr_w;
      sram_r_n  <= !(qdr_ack && qdr_r);
      sram_w_n  <= !(qdr_ack && qdr_w);
      // byte writes only on the two beats of a write
      sram_bw_n <= wr_beat ? ~qdr_be : '1;
    end
  end

  always_ff @(posedge qdr_clk) begin
    if (qdr_ack) begin
      sram_addr <= qdr_addr;
    end
    sram_d <= qdr_d;
  end

  a_one_strobe: assert property (@(posedge qdr_clk) disable iff (qdr_rst)
    !(!sram_r_n && !sram_w_n));

endmodule

`default_nettype wire

// ==== qdr_host_bridge.sv ====
`default_nettype none

module qdr_host_bridge
  import qdr_host_bridge_pkg::*;
(
  input  logic       qdr_clk,
  input  logic       qdr_rst,
  input  logic       host_en,
  input  logic       host_rnw,
  input  host_addr_t host_addr,
  input  host_data_t host_datai,
  input  host_be_t   host_be,
  input  qdr_word_t  sram_q,
  output logic       host_ack,
  output host_data_t host_datao,
  output qdr_addr_t  sram_addr,
  output logic       sram_r_n,
  output logic       sram_w_n,
  output qdr_word_t  sram_d,
  output qdr_be_t    sram_bw_n
);

  // host port to burst adapter
  logic       xfer_req;
  logic       xfer_ack;
  host_addr_t xfer_addr;
  logic       xfer_rnw;
  host_data_t xfer_data;
  host_be_t   xfer_be;
  host_data_t rd_data;

  // burst adapter to command issue
  logic      qdr_req;
  logic      qdr_ack;
  logic      qdr_r;
  logic      qdr_w;
  qdr_addr_t qdr_addr;
  qdr_word_t qdr_d;
  qdr_be_t   qdr_be;
  qdr_word_t qdr_q;

  host_port u_host_port (
    .qdr_clk    (qdr_clk),
    .qdr_rst    (qdr_rst),
    .host_en    (host_en),
    .host_rnw   (host_rnw),
    .host_addr  (host_addr),
    .host_datai (host_datai),
    .host_be    (host_be),
    .xfer_ack   (xfer_ack),
    .rd_data    (rd_data),
    .host_ack   (host_ack),
    .host_datao (host_datao),
    .xfer_req   (xfer_req),
    .xfer_addr  (xfer_addr),
    .xfer_rnw   (xfer_rnw),
    .xfer_data  (xfer_data),
    .xfer_be    (xfer_be)
  );

  qdr_burst_adapter u_burst_adapter (
    .qdr_clk   (qdr_clk),
    .qdr_rst   (qdr_rst),
    .xfer_req  (xfer_req),
    .xfer_addr (xfer_addr),
    .xfer_rnw  (xfer_rnw),
    .xfer_data (xfer_data),
    .xfer_be   (xfer_be),
    .qdr_ack   (qdr_ack),
    .qdr_q     (qdr_q),
    .xfer_ack  (xfer_ack),
    .rd_data   (rd_data),
    .qdr_req   (qdr_req),
    .qdr_r     (qdr_r),
    .qdr_w     (qdr_w),
    .qdr_addr  (qdr_addr),
    .qdr_d     (qdr_d),
    .qdr_be    (qdr_be)
  );

  qdr_cmd_issue u_cmd_issue (
    .qdr_clk   (qdr_clk),
    .qdr_rst   (qdr_rst),
    .qdr_req   (qdr_req),
    .qdr_r     (qdr_r),
    .qdr_w     (qdr_w),
    .qdr_addr  (qdr_addr),
    .qdr_d     (qdr_d),
    .qdr_be    (qdr_be),
    .sram_q    (sram_q),
    .qdr_ack   (qdr_ack),
    .qdr_q     (qdr_q),
    .sram_addr (sram_addr),
    .sram_r_n  (sram_r_n),
    .sram_w_n  (sram_w_n),
    .sram_d    (sram_d),
    .sram_bw_n (sram_bw_n)
  );

endmodule

`default_nettype wire

// ==== qdr_sram_model.sv ====
`default_nettype none

`include "qdr_host_bridge_defs.svh"

module qdr_sram_model
  import qdr_host_bridge_pkg::*;
(
  input  logic      qdr_clk,
  input  logic      qdr_rst,
  input  qdr_addr_t sram_addr,
  input  logic      sram_r_n,
  input  logic      sram_w_n,
  input  qdr_word_t sram_d,
  input  qdr_be_t   sram_bw_n,
  output qdr_word_t sram_q
);

  // ninth bit of every lane, driven high on reads
  localparam qdr_word_t ninth_bits = 36'h8_0402_0100;

  // beat 0 and beat 1 of each burst address
  qdr_word_t mem0 [256];
  qdr_word_t mem1 [256];

  logic       wr_beat1;
  logic [7:0] wr_addr;
  logic [`QDR_READ_LATENCY-1:0] rd_sh;
  logic [7:0] rd_addr [`QDR_READ_LATENCY];

  function automatic qdr_word_t merge_lanes(input qdr_word_t old, input qdr_word_t d,
                                            input qdr_be_t bw_n);
    qdr_word_t r;
    int k;
    r = old;
    for (k = 0; k < 4; k++) begin
      if (!bw_n[k]) begin
        r[9*k +: 9] = d[9*k +: 9];
      end
    end
    return r;
  endfunction

  initial begin
    int i;
    for (i = 0; i < 256; i++) begin
      mem0[i] = {1'b0, 8'(i), 1'b0, 8'(~i), 1'b0, 8'(i ^ 8'h5a), 1'b0, 8'hc3};
      mem1[i] = {1'b0, 8'(~i), 1'b0, 8'(i + 3), 1'b0, 8'h3c, 1'b0, 8'(i)};
    end
  end

  always @(posedge qdr_clk) begin
    if (qdr_rst) begin
      wr_beat1 <= 1'b0;
      rd_sh    <= '0;
    end else begin
      wr_beat1 <= !sram_w_n;
      rd_sh    <= {rd_sh[`QDR_READ_LATENCY-2:0], !sram_r_n};
      // beat 0 is on the pins in the strobe cycle, beat 1 one cycle later
      if (!sram_w_n) begin
        mem0[sram_addr[7:0]] <= merge_lanes(mem0[sram_addr[7:0]], sram_d, sram_bw_n);
        wr_addr <= sram_addr[7:0];
      end
      if (wr_beat1) begin
        mem1[wr_addr] <= merge_lanes(mem1[wr_addr], sram_d, sram_bw_n);
      end
    end
    rd_addr[0] <= sram_addr[7:0];
    for (int k = 1; k < `QDR_READ_LATENCY; k++) begin
      rd_addr[k] <= rd_addr[k-1];
    end
  end

  // beat 0 lands on the bridge latency cycles after its grant cycle
  assign sram_q = rd_sh[`QDR_READ_LATENCY-2] ? (mem0[rd_addr[`QDR_READ_LATENCY-2]] | ninth_bits) :
                  rd_sh[`QDR_READ_LATENCY-1] ? (mem1[rd_addr[`QDR_READ_LATENCY-1]] | ninth_bits) :
                  'x;

endmodule

`default_nettype wire

// ==== tb_qdr_host_bridge.sv ====
`default_nettype none

module tb_qdr_host_bridge
  import qdr_host_bridge_pkg::*;
();

  localparam int num_accesses      = 80;
  localparam int cycles_per_access = 200;

  logic       qdr_clk;
  logic       qdr_rst;
  logic       host_en;
  logic       host_rnw;
  host_addr_t host_addr;
  host_data_t host_datai;
  host_be_t   host_be;
  qdr_word_t  sram_q;
  logic       host_ack;
  host_data_t host_datao;
  qdr_addr_t  sram_addr;
  logic       sram_r_n;
  logic       sram_w_n;
  qdr_word_t  sram_d;
  qdr_be_t    sram_bw_n;

  // expected host words, indexed by address bits 9:2
  host_data_t  ref_mem [256];
  logic [31:0] lfsr_state;

  qdr_host_bridge DUT (
    .qdr_clk    (qdr_clk),
    .qdr_rst    (qdr_rst),
    .host_en    (host_en),
    .host_rnw   (host_rnw),
    .host_addr  (host_addr),
    .host_datai (host_datai),
    .host_be    (host_be),
    .sram_q     (sram_q),
    .host_ack   (host_ack),
    .host_datao (host_datao),
    .sram_addr  (sram_addr),
    .sram_r_n   (sram_r_n),
    .sram_w_n   (sram_w_n),
    .sram_d     (sram_d),
    .sram_bw_n  (sram_bw_n)
  );

  qdr_sram_model u_sram (
    .qdr_clk   (qdr_clk),
    .qdr_rst   (qdr_rst),
    .sram_addr (sram_addr),
    .sram_r_n  (sram_r_n),
    .sram_w_n  (sram_w_n),
    .sram_d    (sram_d),
    .sram_bw_n (sram_bw_n),
    .sram_q    (sram_q)
  );

  initial begin
    qdr_clk = 1'b0;
    forever begin
      #5 qdr_clk = ~qdr_clk;
    end
  end

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    int k;
    r = '0;
    for (k = 0; k < n; k++) begin
      r = {r[30:0], lfsr_state[0]};
      lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
    end
    return r;
  endfunction

  // four bytes in 9-bit lanes, ninth bit zero
  function automatic qdr_word_t pack_lanes(input host_data_t d);
    return {1'b0, d[31:24], 1'b0, d[23:16], 1'b0, d[15:8], 1'b0, d[7:0]};
  endfunction

  task automatic abort_run;
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s = %b, expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_be(input string name, input qdr_be_t got, input qdr_be_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s = %b, expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_addr(input string name, input qdr_addr_t got, input qdr_addr_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_data(input string name, input host_data_t got, input host_data_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_word(input string name, input qdr_word_t got, input qdr_word_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_idle_pins;
    check_bit("host_ack", host_ack, 1'b0);
    check_bit("sram_r_n", sram_r_n, 1'b1);
    check_bit("sram_w_n", sram_w_n, 1'b1);
    check_be("sram_bw_n", sram_bw_n, 4'hf);
  endtask

  task automatic ref_write(input host_addr_t a, input host_data_t d, input host_be_t be);
    int k;
    for (k = 0; k < 4; k++) begin
      if (be[k]) begin
        ref_mem[a[9:2]][8*k +: 8] = d[8*k +: 8];
      end
    end
  endtask

  // one host_en pulse, then wait for host_ack
  task automatic run_access(input logic rnw, input host_addr_t a, input host_data_t d,
                            input host_be_t be);
    @(posedge qdr_clk);
    host_en    <= 1'b1;
    host_rnw   <= rnw;
    host_addr  <= a;
    host_datai <= d;
    host_be    <= be;
    @(posedge qdr_clk);
    host_en <= 1'b0;
    @(posedge qdr_clk);
    while (host_ack !== 1'b1) begin
      @(posedge qdr_clk);
    end
  endtask

  task automatic host_write(input host_addr_t a, input host_data_t d, input host_be_t be);
    run_access(1'b0, a, d, be);
    ref_write(a, d, be);
  endtask

  task automatic host_read(input host_addr_t a);
    run_access(1'b1, a, '0, '0);
    check_data("host_datao", host_datao, ref_mem[a[9:2]]);
  endtask

  // samples the pins at the falling edge of the strobe cycle and the next one
  task automatic expect_write_pins(input host_addr_t a, input qdr_word_t exp_d,
                                   input qdr_be_t bw0, input qdr_be_t bw1);
    @(negedge qdr_clk);
    while (sram_w_n !== 1'b0) begin
      @(negedge qdr_clk);
    end
    // one burst address per eight host bytes
    check_addr("sram_addr", sram_addr, qdr_addr_t'(a / 8));
    check_word("sram_d beat 0", sram_d, exp_d);
    check_be("sram_bw_n beat 0", sram_bw_n, bw0);
    @(negedge qdr_clk);
    check_word("sram_d beat 1", sram_d, exp_d);
    check_be("sram_bw_n beat 1", sram_bw_n, bw1);
  endtask

  task automatic reset_and_check;
    int i;
    for (i = 0; i < 15; i++) begin
      @(negedge qdr_clk);
      check_idle_pins();
    end
    @(posedge qdr_clk);
    qdr_rst <= 1'b0;
    for (i = 0; i < 4; i++) begin
      @(negedge qdr_clk);
      check_idle_pins();
    end
  endtask

  task automatic test_write_format;
    host_data_t d;
    d = rand_bits(32);
    fork
      host_write(32'h40, d, 4'b1011);
      expect_write_pins(32'h40, pack_lanes(d), 4'b0100, 4'hf);
    join
    d = rand_bits(32);
    fork
      host_write(32'h44, d, 4'b0110);
      expect_write_pins(32'h44, pack_lanes(d), 4'hf, 4'b1001);
    join
  endtask

  task automatic test_read_words;
    host_write(32'h80, 32'h1234_5678, 4'hf);
    host_write(32'h84, 32'h9abc_def0, 4'hf);
    host_read(32'h80);
    host_read(32'h84);
    // rewriting the low word must leave the high word alone
    host_write(32'h80, 32'hcafe_f00d, 4'hf);
    host_read(32'h80);
    host_read(32'h84);
  endtask

  task automatic test_byte_enables;
    host_write(32'h88, 32'h0102_0304, 4'hf);
    host_write(32'h88, 32'haabb_ccdd, 4'b0101);
    host_read(32'h88);
    host_write(32'h8c, 32'h5566_7788, 4'hf);
    host_write(32'h8c, 32'hee00_0000, 4'b1000);
    host_read(32'h8c);
    host_read(32'h88);
  endtask

  task automatic test_random;
    host_addr_t a;
    host_data_t d;
    host_be_t   be;
    logic       rnw;
    int         i;
    // known contents first, so every later read has an expected value
    for (i = 0; i < 16; i++) begin
      host_write(32'h100 + 4 * i, rand_bits(32), 4'hf);
    end
    for (i = 0; i < 40; i++) begin
      rnw = 1'(rand_bits(1));
      a   = 32'h100 + 4 * rand_bits(4);
      if (rnw) begin
        host_read(a);
      end else begin
        d  = rand_bits(32);
        be = host_be_t'(rand_bits(4));
        host_write(a, d, be);
      end
    end
  endtask

  initial begin
    qdr_rst    = 1'b1;
    host_en    = 1'b0;
    host_rnw   = 1'b0;
    host_addr  = '0;
    host_datai = '0;
    host_be    = '0;
    lfsr_state = 32'h65e6;
    reset_and_check();
    test_write_format();
    test_read_words();
    test_byte_enables();
    test_random();
    repeat (4) begin
      @(posedge qdr_clk);
    end
    $display("*** PASSED ***");
    $finish;
  end

  initial begin
    repeat (32 + cycles_per_access * num_accesses) begin
      @(posedge qdr_clk);
    end
    $display("watchdog timeout, the host accesses did not complete in time");
    abort_run();
  end

endmodule

`default_nettype wire

// ==== qdr_host_bridge.f ====
+incdir+.
qdr_host_bridge_pkg.sv
host_port.sv
qdr_burst_adapter.sv
qdr_cmd_issue.sv
qdr_host_bridge.sv
qdr_sram_model.sv
tb_qdr_host_bridge.sv
